//--- design/bpu_defines.svh
// Sizing macros for the branch prediction unit
// Entry counts must be powers of two because indexes are taken straight from PC bits
// The BTB index always starts at PC bit 2, so instructions are assumed word aligned

`ifndef BPU_DEFINES_SVH
`define BPU_DEFINES_SVH

// Width of every program counter value
`define BPU_PC_W 32

// Direct-mapped BTB entries, indexed by PC[7:2] at the default size
`define BPU_BTB_ENTRIES 64

// Pattern table entries, which also sets the global history length
`define BPU_PHT_ENTRIES 1024

// Conditional predictions that can wait for execute at once
`define BPU_FIFO_DEPTH 8

`endif

//--- design/bpu_pkg.sv
// Types shared by the BTB, the gshare predictor and the next-PC selector
// Field order inside the structs is part of the interface to fetch and execute

`include "bpu_defines.svh"

package bpu_pkg;

    // Kind of control transfer held in the BTB and reported by execute
    typedef enum logic {
        BR_COND = 1'b0,
        BR_JUMP = 1'b1
    } branch_kind_e;

    // ==============================
    // Fetch side
    // ==============================

    // Result of a BTB lookup, valid in the same cycle as the fetch PC
    typedef struct packed {
        logic                   hit;
        branch_kind_e           kind;
        logic [`BPU_PC_W-1:0]   target;
    } btb_lookup_t;

    // ==============================
    // Execute side
    // ==============================

    // One branch resolved in execute, delivered in program order
    typedef struct packed {
        logic                   valid;
        branch_kind_e           kind;
        logic                   taken;
        logic [`BPU_PC_W-1:0]   pc;
        logic [`BPU_PC_W-1:0]   target;
    } resolve_t;

endpackage

//--- design/branch_target_buffer.sv
// Direct-mapped BTB with a combinational read port and one write port from execute
// Only taken branches allocate, so a conditional branch needs to be taken once to be seen
// A new allocation simply overwrites whatever lived at that index

`timescale 1ns/100ps

`include "bpu_defines.svh"

module branch_target_buffer
    import bpu_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic [`BPU_PC_W-1:0]    fetch_pc_i,
    input  resolve_t                resolve_i,
    output btb_lookup_t             lookup_o
);

    localparam int IDX_W = $clog2(`BPU_BTB_ENTRIES);
    localparam int TAG_W = `BPU_PC_W - IDX_W - 2;

    // ==============================
    // Storage
    // ==============================

    // Only the valid bits are control state; the rest is payload
    logic [`BPU_BTB_ENTRIES-1:0]    valid_q;
    logic [TAG_W-1:0]               tag_mem    [`BPU_BTB_ENTRIES];
    branch_kind_e                   kind_mem   [`BPU_BTB_ENTRIES];
    logic [`BPU_PC_W-1:0]           target_mem [`BPU_BTB_ENTRIES];

    // ==============================
    // Lookup
    // ==============================

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;

    // Bits [1:0] are always zero for aligned instructions and are skipped
    assign rd_idx = fetch_pc_i[IDX_W+1:2];
    assign rd_tag = fetch_pc_i[`BPU_PC_W-1:IDX_W+2];

    always_comb begin
        lookup_o.hit    = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
        lookup_o.kind   = kind_mem[rd_idx];
        lookup_o.target = target_mem[rd_idx];
    end

    // ==============================
    // Allocation
    // ==============================

    logic             alloc;
    logic [IDX_W-1:0] wr_idx;

    // Any resolved taken branch, jump or conditional, claims its slot
    assign alloc  = resolve_i.valid && resolve_i.taken;
    assign wr_idx = resolve_i.pc[IDX_W+1:2];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (alloc) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Tag, kind and target of the allocated slot
    always_ff @(posedge clk_i) begin
        if (alloc) begin
            tag_mem[wr_idx]    <= resolve_i.pc[`BPU_PC_W-1:IDX_W+2];
            kind_mem[wr_idx]   <= resolve_i.kind;
            target_mem[wr_idx] <= resolve_i.target;
        end
    end

    // An unknown kind from execute would corrupt both the BTB and the predictor FIFO
    a_resolve_kind_known : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        resolve_i.valid |-> !$isunknown(resolve_i.kind)
    );

endmodule

//--- design/gshare_predictor.sv
// Gshare direction predictor with an in-order FIFO of guesses awaiting execute
// Resolves must arrive in program order, one per cycle at most
// Pushing into a full FIFO is illegal and is not back-pressured

`timescale 1ns/100ps

`include "bpu_defines.svh"

module gshare_predictor
    import bpu_pkg::*;
#(
    parameter int TABLE_SIZE = `BPU_PHT_ENTRIES
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    stall_i,
    input  logic                    fetch_valid_i,
    input  logic [`BPU_PC_W-1:0]    fetch_pc_i,
    input  btb_lookup_t             lookup_i,
    input  resolve_t                resolve_i,
    output logic                    prediction_o,
    output logic                    mispredicted_o
);

    localparam int IDX_W = $clog2(TABLE_SIZE);
    localparam int PTR_W = $clog2(`BPU_FIFO_DEPTH);

    // Guess plus the table slot it came from, so the update hits the same counter
    typedef struct packed {
        logic               guess;
        logic [IDX_W-1:0]   index;
    } fifo_entry_t;

    logic             push;
    logic             pull;
    logic             resolve_cond;
    logic [IDX_W-1:0] history_q;
    logic [IDX_W-1:0] hashed_idx;
    logic [1:0]       pht [TABLE_SIZE];

    // ==============================
    // Prediction
    // ==============================

    // History mixed with the branch PC word index
    assign hashed_idx   = history_q ^ fetch_pc_i[IDX_W+1:2];
    // Counter values 2 and 3 mean taken
    assign prediction_o = pht[hashed_idx][1];

    // Only conditional hits are queued, jumps need no direction
    assign push = fetch_valid_i && lookup_i.hit && (lookup_i.kind == BR_COND) && !stall_i;

    // ==============================
    // Prediction FIFO
    // ==============================

    fifo_entry_t      fifo_mem [`BPU_FIFO_DEPTH];
    fifo_entry_t      head;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             empty;
    logic             full;

    assign empty = (count_q == '0);
    assign full  = (count_q == (PTR_W+1)'(`BPU_FIFO_DEPTH));
    assign head  = fifo_mem[rd_ptr_q];

    assign resolve_cond = resolve_i.valid && (resolve_i.kind == BR_COND);
    // An empty FIFO means the guess was already flushed, so nothing is pulled
    assign pull = resolve_cond && !empty;

    assign mispredicted_o = pull && (resolve_i.taken != head.guess);

    // A misprediction drops every younger guess, including one pushed this cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || mispredicted_o) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + PTR_W'(1);
            end
            if (pull) begin
                rd_ptr_q <= rd_ptr_q + PTR_W'(1);
            end
            count_q <= count_q + (PTR_W+1)'(push) - (PTR_W+1)'(pull);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_mem[wr_ptr_q] <= '{guess: prediction_o, index: hashed_idx};
        end
    end

    // ==============================
    // History and counter update
    // ==============================

    // Newest outcome enters bit 0, shifted even when the FIFO was flushed
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            history_q <= '0;
        end else if (resolve_cond) begin
            history_q <= {history_q[IDX_W-2:0], resolve_i.taken};
        end
    end

    logic [1:0] cnt_old;
    logic [1:0] cnt_new;

    assign cnt_old = pht[head.index];

    // Two-bit saturating step toward the resolved direction
    always_comb begin
        cnt_new = cnt_old;
        if (resolve_i.taken && cnt_old != 2'b11) begin
            cnt_new = cnt_old + 2'b01;
        end else if (!resolve_i.taken && cnt_old != 2'b00) begin
            cnt_new = cnt_old - 2'b01;
        end
    end

    // Every counter starts strongly not taken
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < TABLE_SIZE; i++) begin
                pht[i] <= 2'b00;
            end
        end else if (pull) begin
            pht[head.index] <= cnt_new;
        end
    end

    a_no_push_when_full : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        push |-> (!full || pull)
    );

    // A resolved conditional must meet a written FIFO slot and a known outcome
    a_mispredict_known : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        resolve_cond |-> !$isunknown(mispredicted_o)
    );

endmodule

//--- design/next_pc_select.sv
// Next fetch PC mux, purely combinational
// A misprediction always wins over anything the current fetch predicts
// Jumps that miss in the BTB fall through to PC+4 and are fixed up by the pipeline

`timescale 1ns/100ps

`include "bpu_defines.svh"

module next_pc_select
    import bpu_pkg::*;
(
    input  logic [`BPU_PC_W-1:0]    fetch_pc_i,
    input  btb_lookup_t             lookup_i,
    input  logic                    prediction_i,
    input  logic                    mispredicted_i,
    input  resolve_t                resolve_i,
    output logic [`BPU_PC_W-1:0]    next_pc_o,
    output logic                    pred_taken_o,
    output logic                    redirect_o
);

    localparam logic [`BPU_PC_W-1:0] INSN_BYTES = `BPU_PC_W'(4);

    logic [`BPU_PC_W-1:0] recover_pc;
    logic                 go_target;

    // Correct path after a wrong guess, from the resolved branch itself
    assign recover_pc = resolve_i.taken ? resolve_i.target : (resolve_i.pc + INSN_BYTES);

    // Jumps are always taken, conditionals follow the counter
    assign go_target = lookup_i.hit && ((lookup_i.kind == BR_JUMP) || prediction_i);

    always_comb begin
        redirect_o   = 1'b0;
        pred_taken_o = 1'b0;
        next_pc_o    = fetch_pc_i + INSN_BYTES;
        if (mispredicted_i) begin
            redirect_o = 1'b1;
            next_pc_o  = recover_pc;
        end else if (go_target) begin
            pred_taken_o = 1'b1;
            next_pc_o    = lookup_i.target;
        end
    end

endmodule

//--- design/branch_prediction_unit.sv
// Front-end branch prediction unit, top level
// Next PC, prediction and redirect are combinational from the fetch and resolve inputs

`timescale 1ns/100ps

`include "bpu_defines.svh"

module branch_prediction_unit
    import bpu_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    stall_i,
    input  logic                    fetch_valid_i,
    input  logic [`BPU_PC_W-1:0]    fetch_pc_i,
    input  resolve_t                resolve_i,
    output logic [`BPU_PC_W-1:0]    next_pc_o,
    output logic                    pred_taken_o,
    output logic                    redirect_o
);

    btb_lookup_t lookup;
    logic        prediction;
    logic        mispredicted;

    // Target and kind for the current fetch PC
    branch_target_buffer u_btb (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .fetch_pc_i (fetch_pc_i),
        .resolve_i  (resolve_i),
        .lookup_o   (lookup)
    );

    // Direction guess and misprediction check
    gshare_predictor #(
        .TABLE_SIZE (`BPU_PHT_ENTRIES)
    ) u_gshare (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .stall_i        (stall_i),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_pc_i     (fetch_pc_i),
        .lookup_i       (lookup),
        .resolve_i      (resolve_i),
        .prediction_o   (prediction),
        .mispredicted_o (mispredicted)
    );

    next_pc_select u_npc (
        .fetch_pc_i     (fetch_pc_i),
        .lookup_i       (lookup),
        .prediction_i   (prediction),
        .mispredicted_i (mispredicted),
        .resolve_i      (resolve_i),
        .next_pc_o      (next_pc_o),
        .pred_taken_o   (pred_taken_o),
        .redirect_o     (redirect_o)
    );

endmodule

//--- verification/tb_bpu.sv
// Directed testbench for the branch prediction unit with a cycle-level reference model
// Inputs change on the falling edge and outputs are checked 1 ns later
// The model advances after each rising edge from the inputs that were driven

`timescale 1ns/100ps

`include "bpu_defines.svh"

module tb_bpu
    import bpu_pkg::*;
();

    localparam int BTB_IDX_W = $clog2(`BPU_BTB_ENTRIES);
    localparam int TAG_W     = `BPU_PC_W - BTB_IDX_W - 2;
    localparam int HIST_W    = $clog2(`BPU_PHT_ENTRIES);
    // Jump and conditional branch sit at different BTB indexes
    localparam logic [31:0] JMP_PC  = 32'h0000_1040;
    localparam logic [31:0] JMP_TGT = 32'h0000_2000;
    localparam logic [31:0] BR_PC   = 32'h0000_3080;
    localparam logic [31:0] BR_TGT  = 32'h0000_3400;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        stall;
    logic        fetch_valid;
    logic [31:0] fetch_pc;
    resolve_t    resolve;
    logic [31:0] next_pc;
    logic        pred_taken;
    logic        redirect;

    branch_prediction_unit u_dut (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .stall_i       (stall),
        .fetch_valid_i (fetch_valid),
        .fetch_pc_i    (fetch_pc),
        .resolve_i     (resolve),
        .next_pc_o     (next_pc),
        .pred_taken_o  (pred_taken),
        .redirect_o    (redirect)
    );

    always #5 clk = ~clk;

    // ==============================
    // Reference model state
    // ==============================

    logic         m_btb_valid  [`BPU_BTB_ENTRIES];
    logic [TAG_W-1:0] m_btb_tag [`BPU_BTB_ENTRIES];
    branch_kind_e m_btb_kind   [`BPU_BTB_ENTRIES];
    logic [31:0]  m_btb_target [`BPU_BTB_ENTRIES];
    logic [HIST_W-1:0] m_hist;
    logic [1:0]   m_pht [`BPU_PHT_ENTRIES];
    // In-flight guesses in program order, with their table index and branch PC
    logic              q_guess [$];
    logic [HIST_W-1:0] q_index [$];
    logic [31:0]       q_pc    [$];

    logic              e_hit;
    branch_kind_e      e_kind;
    logic [31:0]       e_target;
    logic [HIST_W-1:0] e_index;
    logic              e_pred;
    logic              e_push;
    logic              e_pull;
    logic              e_mis;
    logic [31:0]       exp_next;
    logic              exp_taken;
    logic              exp_redirect;
    logic [31:0]       obs_next;
    logic              obs_taken;
    logic              obs_redirect;

    logic [15:0] lfsr = 16'd18;
    string       test_name;
    int          checks;
    int          mismatches;
    int          timeouts;

    // Fibonacci LFSR with taps 16, 14, 13, 11, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic resolve_t make_resolve(input logic v, input branch_kind_e k,
                                              input logic t, input logic [31:0] pc,
                                              input logic [31:0] tgt);
        resolve_t r;
        r.valid  = v;
        r.kind   = k;
        r.taken  = t;
        r.pc     = pc;
        r.target = tgt;
        return r;
    endfunction

    task automatic check_val(input string field, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        checks++;
        assert (exp_v === act_v) else begin
            mismatches++;
            $display("MISMATCH %s %s expected %h actual %h", test_name, field, exp_v, act_v);
        end
    endtask

    // ==============================
    // Model evaluation and update
    // ==============================

    // Expected outputs for the inputs currently on the DUT
    task automatic expected_outputs();
        logic [BTB_IDX_W-1:0] bi;
        bi       = fetch_pc[BTB_IDX_W+1:2];
        e_hit    = m_btb_valid[bi] && (m_btb_tag[bi] == fetch_pc[31:BTB_IDX_W+2]);
        e_kind   = m_btb_kind[bi];
        e_target = m_btb_target[bi];
        e_index  = m_hist ^ fetch_pc[HIST_W+1:2];
        e_pred   = m_pht[e_index][1];
        e_push   = fetch_valid && e_hit && (e_kind == BR_COND) && !stall;
        e_pull   = resolve.valid && (resolve.kind == BR_COND) && (q_guess.size() > 0);
        e_mis    = 1'b0;
        if (e_pull) begin
            e_mis = (resolve.taken != q_guess[0]);
        end
        exp_redirect = e_mis;
        exp_taken    = !e_mis && e_hit && ((e_kind == BR_JUMP) || e_pred);
        if (e_mis) begin
            exp_next = resolve.taken ? resolve.target : resolve.pc + 32'd4;
        end else if (exp_taken) begin
            exp_next = e_target;
        end else begin
            exp_next = fetch_pc + 32'd4;
        end
    endtask

    // State change at the rising edge, using values from expected_outputs
    task automatic advance_model();
        logic [1:0]           c;
        logic [BTB_IDX_W-1:0] wi;
        if (e_pull) begin
            c = m_pht[q_index[0]];
            if (resolve.taken && c != 2'd3) begin
                c = c + 2'd1;
            end else if (!resolve.taken && c != 2'd0) begin
                c = c - 2'd1;
            end
            m_pht[q_index[0]] = c;
        end
        if (e_mis) begin
            q_guess.delete();
            q_index.delete();
            q_pc.delete();
        end else begin
            if (e_pull) begin
                void'(q_guess.pop_front());
                void'(q_index.pop_front());
                void'(q_pc.pop_front());
            end
            if (e_push) begin
                q_guess.push_back(e_pred);
                q_index.push_back(e_index);
                q_pc.push_back(fetch_pc);
            end
        end
        if (resolve.valid && resolve.kind == BR_COND) begin
            m_hist = {m_hist[HIST_W-2:0], resolve.taken};
        end
        if (resolve.valid && resolve.taken) begin
            wi               = resolve.pc[BTB_IDX_W+1:2];
            m_btb_valid[wi]  = 1'b1;
            m_btb_tag[wi]    = resolve.pc[31:BTB_IDX_W+2];
            m_btb_kind[wi]   = resolve.kind;
            m_btb_target[wi] = resolve.target;
        end
    endtask

    // One cycle of stimulus, compared against the model before the edge
    task automatic run_cycle(input logic fv, input logic st, input logic [31:0] pc,
                             input resolve_t rs);
        @(negedge clk);
        fetch_valid = fv;
        stall       = st;
        fetch_pc    = pc;
        resolve     = rs;
        #1;
        obs_next     = next_pc;
        obs_taken    = pred_taken;
        obs_redirect = redirect;
        expected_outputs();
        check_val("next_pc", exp_next, obs_next);
        check_val("pred_taken", 32'(exp_taken), 32'(obs_taken));
        check_val("redirect", 32'(exp_redirect), 32'(obs_redirect));
        @(posedge clk);
        advance_model();
    endtask

    task automatic apply_reset();
        rst_n       = 1'b0;
        stall       = 1'b0;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        resolve     = make_resolve(1'b0, BR_COND, 1'b0, '0, '0);
        m_hist      = '0;
        for (int i = 0; i < `BPU_BTB_ENTRIES; i++) begin
            m_btb_valid[i] = 1'b0;
        end
        for (int i = 0; i < `BPU_PHT_ENTRIES; i++) begin
            m_pht[i] = 2'd0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    endtask

    // ==============================
    // Directed tests
    // ==============================

    task automatic reset_defaults();
        logic [31:0] pc;
        test_name = "after_reset";
        for (int n = 0; n < 4; n++) begin
            pc = take_bits(30) << 2;
            run_cycle(1'b1, 1'b0, pc, make_resolve(1'b0, BR_COND, 1'b0, '0, '0));
            check_val("seq_pc", pc + 32'd4, obs_next);
            check_val("taken_low", 32'd0, 32'(obs_taken));
            check_val("redirect_low", 32'd0, 32'(obs_redirect));
        end
    endtask

    task automatic jump_allocation();
        test_name = "btb_jump";
        run_cycle(1'b0, 1'b0, '0, make_resolve(1'b1, BR_JUMP, 1'b1, JMP_PC, JMP_TGT));
        run_cycle(1'b1, 1'b0, JMP_PC, make_resolve(1'b0, BR_COND, 1'b0, '0, '0));
        check_val("jump_target", JMP_TGT, obs_next);
        check_val("jump_taken", 32'd1, 32'(obs_taken));
        // Same index, different tag, so the entry must not match
        run_cycle(1'b1, 1'b0, JMP_PC + 32'h100, make_resolve(1'b0, BR_COND, 1'b0, '0, '0));
        check_val("alias_pc", JMP_PC + 32'h104, obs_next);
        check_val("alias_taken", 32'd0, 32'(obs_taken));
    endtask

    task automatic counter_training();
        int tries;
        test_name = "cond_training";
        // Taken once with nothing in flight, only to allocate the BTB entry
        run_cycle(1'b0, 1'b0, '0, make_resolve(1'b1, BR_COND, 1'b1, BR_PC, BR_TGT));
        run_cycle(1'b1, 1'b0, BR_PC, make_resolve(1'b0, BR_COND, 1'b0, '0, '0));
        check_val("first_guess", 32'd0, 32'(obs_taken));
        run_cycle(1'b0, 1'b0, '0, make_resolve(1'b1, BR_COND, 1'b1, BR_PC, BR_TGT));
        check_val("redirect_high", 32'd1, 32'(obs_redirect));
        check_val("redirect_pc", BR_TGT, obs_next);
        tries = 0;
        run_cycle(1'b1, 1'b0, BR_PC, make_resolve(1'b0, BR_COND, 1'b0, '0, '0));
        while (!exp_taken && tries < 40) begin
            run_cycle(1'b0, 1'b0, '0, make_resolve(1'b1, BR_COND, 1'b1, BR_PC, BR_TGT));
            run_cycle(1'b1, 1'b0, BR_PC, make_resolve(1'b0, BR_COND, 1'b0, '0, '0));
            tries++;
        end
        assert (exp_taken) else begin
            timeouts++;
            $display("Timeout in %s: counter never reached taken", test_name);
        end
        // Retire the last guess so the FIFO is empty again
        run_cycle(1'b0, 1'b0, '0, make_resolve(1'b1, BR_COND, 1'b1, BR_PC, BR_TGT));
    endtask

    task automatic flush_on_mispredict();
        logic guess;
        test_name = "flush";
        run_cycle(1'b1, 1'b0, BR_PC, make_resolve(1'b0, BR_COND, 1'b0, '0, '0));
        guess = e_pred;
        run_cycle(1'b1, 1'b0, BR_PC, make_resolve(1'b0, BR_COND, 1'b0, '0, '0));
        run_cycle(1'b0, 1'b0, '0, make_resolve(1'b1, BR_COND, !guess, BR_PC, BR_TGT));
        check_val("first_wrong", 32'd1, 32'(obs_redirect));
        // The second guess matches the first, so a stale entry would mispredict here
        run_cycle(1'b0, 1'b0, '0, make_resolve(1'b1, BR_COND, !guess, BR_PC, BR_TGT));
        check_val("after_flush", 32'd0, 32'(obs_redirect));
    endtask

    task automatic stall_blocks_queue();
        logic guess;
        test_name = "stall";
        run_cycle(1'b1, 1'b1, BR_PC, make_resolve(1'b0, BR_COND, 1'b0, '0, '0));
        guess = e_pred;
        run_cycle(1'b1, 1'b1, BR_PC, make_resolve(1'b0, BR_COND, 1'b0, '0, '0));
        run_cycle(1'b0, 1'b0, '0, make_resolve(1'b1, BR_COND, !guess, BR_PC, BR_TGT));
        check_val("no_queue", 32'd0, 32'(obs_redirect));
    endtask

    task automatic random_traffic();
        logic        fv;
        logic        st;
        logic [31:0] pc;
        logic [31:0] rpc;
        resolve_t    rs;
        test_name = "random_mix";
        for (int n = 0; n < 400; n++) begin
            pc  = 32'h0000_5000 | (take_bits(4) << 2) | (take_bits(1) << 8);
            fv  = (take_bits(1) != 0) && (q_pc.size() < `BPU_FIFO_DEPTH - 1);
            st  = (take_bits(2) == 32'd3);
            rs  = make_resolve(1'b0, BR_COND, 1'b0, '0, '0);
            if (take_bits(1) != 0) begin
                if (q_pc.size() > 0) begin
                    rs = make_resolve(1'b1, BR_COND, take_bits(1) != 0, q_pc[0],
                                      q_pc[0] + 32'h40);
                end else begin
                    // Out-of-band resolve, mostly to fill the BTB
                    rpc = 32'h0000_5000 | (take_bits(4) << 2) | (take_bits(1) << 8);
                    rs  = make_resolve(1'b1, (take_bits(1) != 0) ? BR_JUMP : BR_COND,
                                       take_bits(1) != 0, rpc,
                                       32'h0000_6000 | (take_bits(6) << 2));
                end
            end
            run_cycle(fv, st, pc, rs);
        end
    endtask

    initial begin
        checks     = 0;
        mismatches = 0;
        timeouts   = 0;
        apply_reset();
        reset_defaults();
        jump_allocation();
        counter_training();
        flush_on_mispredict();
        stall_blocks_queue();
        random_traffic();
        $display("checks %0d mismatches %0d timeouts %0d", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+design
design/bpu_pkg.sv
design/branch_target_buffer.sv
design/gshare_predictor.sv
design/next_pc_select.sv
design/branch_prediction_unit.sv
verification/tb_bpu.sv

//--- Makefile
# Verilator flow for the branch prediction unit
# Override any variable on the command line, e.g. make sim LOG=run.log

TOP       ?= tb_bpu
LOG       ?= sim.log
VERILATOR ?= verilator
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert --timing

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# Pass or fail is decided only by the pass line in the log
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
